//--- Bender.yml
package:
  name: fb_ctrl

sources:
  - verilog/fb_pkg.sv
  - verilog/vga_pkg.sv
  - verilog/frame_sequencer.sv
  - verilog/sram_arbiter.sv
  - verilog/vga_timing.sv
  - verilog/scanout.sv
  - verilog/fb_top.sv
  - target: test
    files:
      - test/sram_model.sv
      - test/fb_props.sv
      - test/fb_tb.sv

//--- test/fb_props.sv
`timescale 1ns/1ps

module fb_props (
   input logic             VGA_CTRL_CLK,
   input logic             rst,
   input logic             busy,
   input logic             draw_grant,
   input logic             sram_we_n,
   input fb_pkg::fb_word_t sram_dq
);

   int fail_count = 0;  // Assertion failures seen so far

   // Scan-out only reads
   idle_no_write: assert property (@(posedge VGA_CTRL_CLK) disable iff (rst)
      !busy |-> sram_we_n)
      else begin
         fail_count++;
         $error("SRAM write while the controller is idle");
      end

   // Busy without grant means clearing
   clear_writes_zero: assert property (@(posedge VGA_CTRL_CLK) disable iff (rst)
      (busy && !draw_grant && !sram_we_n) |-> (sram_dq == '0))
      else begin
         fail_count++;
         $error("Clear sweep wrote a nonzero word");
      end

   grant_needs_busy: assert property (@(posedge VGA_CTRL_CLK) disable iff (rst)
      draw_grant |-> busy)
      else begin
         fail_count++;
         $error("Draw grant high while the controller is idle");
      end

endmodule

bind fb_top fb_props u_props (
   .VGA_CTRL_CLK (VGA_CTRL_CLK),
   .rst          (rst),
   .busy         (busy),
   .draw_grant   (draw_grant),
   .sram_we_n    (sram_we_n),
   .sram_dq      (sram_dq)
);

//--- test/fb_tb.sv
`timescale 1ns/1ps

module fb_tb;
   import fb_pkg::*;
   import vga_pkg::*;

   localparam int X_BITS = 4;
   localparam int Y_BITS = 4;
   localparam int H_ACTIVE = 24;
   localparam int H_FP = 2;
   localparam int H_SYNC = 4;
   localparam int H_BP = 2;
   localparam int V_ACTIVE = 20;
   localparam int V_FP = 1;
   localparam int V_SYNC = 2;
   localparam int V_BP = 1;
   localparam int A_BITS = X_BITS + Y_BITS;
   localparam int WORDS = 1 << A_BITS;
   localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
   localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
   localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
   localparam int TIMEOUT_CYCLES = 5 * FRAME_CYCLES + 2 * WORDS;  // Five frames plus two sweeps

   logic              VGA_CTRL_CLK;
   logic              rst;
   logic              clear_req;
   logic              draw_req;
   logic              eng_done;
   fb_write_t         eng_wr;
   logic              busy;
   logic              draw_grant;
   logic [A_BITS-1:0] sram_addr;
   wire fb_word_t     sram_dq;
   logic              sram_we_n;
   vga_sync_t         vga_sync;
   rgb_t              vga_rgb;

   fb_word_t ref_mem [WORDS];  // Expected framebuffer
   int errors = 0;
   int checks = 0;
   int cycles = 0;
   int h_cnt;   // Expected scan position
   int v_cnt;
   int h_prev;  // Position shown on the outputs now
   int v_prev;

   fb_top #(
      .X_BITS (X_BITS), .Y_BITS (Y_BITS),
      .H_ACTIVE (H_ACTIVE), .H_FP (H_FP), .H_SYNC (H_SYNC), .H_BP (H_BP),
      .V_ACTIVE (V_ACTIVE), .V_FP (V_FP), .V_SYNC (V_SYNC), .V_BP (V_BP)
   ) DUT (.*);

   sram_model #(.A_BITS (A_BITS)) u_sram (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .addr         (sram_addr),
      .dq           (sram_dq),
      .we_n         (sram_we_n)
   );

   initial begin
      VGA_CTRL_CLK = 1'b0;
      forever #5 VGA_CTRL_CLK = ~VGA_CTRL_CLK;  // 10 ns period
   end

   // Raster position with active area first in line and frame
   always @(posedge VGA_CTRL_CLK) begin
      if (rst) begin
         h_cnt <= 0;
         v_cnt <= 0;
         h_prev <= 0;
         v_prev <= 0;
      end else begin
         h_prev <= h_cnt;  // Outputs lag by one cycle
         v_prev <= v_cnt;
         if (h_cnt == H_TOTAL - 1) begin
            h_cnt <= 0;
            v_cnt <= (v_cnt == V_TOTAL - 1) ? 0 : v_cnt + 1;
         end else begin
            h_cnt <= h_cnt + 1;
         end
      end
   end

   task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // 5-bit fields padded with five zeros
   function automatic logic [31:0] expand_word(input fb_word_t w);
      return {2'b00, w[15:11], 5'b0, w[10:6], 5'b0, w[5:1], 5'b0};
   endfunction

   function automatic fb_write_t make_write(input logic [A_BITS-1:0] a, input fb_word_t d);
      return {{(20-A_BITS){1'b0}}, a, d, 1'b1};
   endfunction

   task automatic preload_random();
      fb_word_t w;
      @(negedge VGA_CTRL_CLK);  // Between scan reads
      for (int a = 0; a < WORDS; a++) begin
         w = fb_word_t'($urandom);
         ref_mem[a] = w;
         u_sram.mem[a] = w;
      end
   endtask

   task automatic compare_memory(input string what);
      int bad;
      bad = 0;
      for (int a = 0; a < WORDS; a++) begin
         if (u_sram.mem[a] !== ref_mem[a]) bad++;
      end
      expect_eq({what, " mismatching words"}, bad, 0);
   endtask

   task automatic check_reset_state();
      @(negedge VGA_CTRL_CLK);
      expect_eq("busy", busy, 1'b0);
      expect_eq("draw_grant", draw_grant, 1'b0);
      expect_eq("sram_we_n", sram_we_n, 1'b1);
      expect_eq("vga_sync", vga_sync, 3'b110);  // hs and vs high and blanked
      expect_eq("vga_rgb", vga_rgb, '0);
   endtask

   // Clear sweep with an optional draw request that must be lost
   task automatic run_clear(input bit poke_draw);
      int busy_cycles;
      busy_cycles = 0;
      preload_random();
      @(posedge VGA_CTRL_CLK);
      clear_req <= 1'b1;
      @(posedge VGA_CTRL_CLK);
      clear_req <= 1'b0;
      draw_req <= poke_draw;  // Seen while clearing
      @(negedge VGA_CTRL_CLK);
      while (busy) begin
         busy_cycles++;
         @(posedge VGA_CTRL_CLK);
         draw_req <= 1'b0;
         @(negedge VGA_CTRL_CLK);
      end
      expect_eq("busy cycles", busy_cycles, WORDS);
      for (int a = 0; a < WORDS; a++) ref_mem[a] = '0;
      compare_memory("clear");
      repeat (poke_draw ? 4 : 0) begin
         expect_eq("draw_grant", draw_grant, 1'b0);
         expect_eq("busy", busy, 1'b0);
         @(negedge VGA_CTRL_CLK);
      end
   endtask

   task automatic check_display();
      logic        in_active;
      logic        in_window;
      logic [31:0] exp_rgb;
      preload_random();
      repeat (FRAME_CYCLES) begin
         @(negedge VGA_CTRL_CLK);
         in_active = (h_prev < H_ACTIVE) && (v_prev < V_ACTIVE);
         in_window = (h_prev < (1 << X_BITS)) && (v_prev < (1 << Y_BITS));
         exp_rgb = '0;
         if (in_active && in_window) exp_rgb = expand_word(ref_mem[(v_prev << X_BITS) + h_prev]);
         expect_eq("vga_rgb", vga_rgb, exp_rgb);
         expect_eq("vga_sync.blank_n", vga_sync.blank_n, in_active);
      end
   endtask

   task automatic check_draw();
      logic [A_BITS-1:0] a;
      fb_word_t          d;
      @(posedge VGA_CTRL_CLK);
      eng_wr <= make_write(A_BITS'($urandom_range(WORDS - 1)), fb_word_t'($urandom));
      @(negedge VGA_CTRL_CLK);
      expect_eq("sram_we_n", sram_we_n, 1'b1);  // No grant yet
      @(posedge VGA_CTRL_CLK);
      eng_wr <= '0;
      draw_req <= 1'b1;
      @(negedge VGA_CTRL_CLK);
      expect_eq("draw_grant", draw_grant, 1'b0);
      @(posedge VGA_CTRL_CLK);
      draw_req <= 1'b0;
      @(negedge VGA_CTRL_CLK);
      expect_eq("draw_grant", draw_grant, 1'b1);  // Next cycle after request
      repeat (8) begin
         @(posedge VGA_CTRL_CLK);
         a = A_BITS'($urandom_range(WORDS - 1));
         d = fb_word_t'($urandom);
         eng_wr <= make_write(a, d);
         ref_mem[a] = d;  // Last write to a word wins
      end
      @(posedge VGA_CTRL_CLK);
      eng_wr <= '0;
      eng_done <= 1'b1;
      @(negedge VGA_CTRL_CLK);
      expect_eq("draw_grant", draw_grant, 1'b1);
      @(posedge VGA_CTRL_CLK);
      eng_done <= 1'b0;
      @(negedge VGA_CTRL_CLK);
      expect_eq("draw_grant", draw_grant, 1'b0);
      compare_memory("draw");
   endtask

   // Any window of one line or one frame holds a full pulse
   task automatic check_sync_widths();
      int hs_low;
      int vs_low;
      vs_low = 0;
      repeat (V_TOTAL) begin
         hs_low = 0;
         repeat (H_TOTAL) begin
            @(negedge VGA_CTRL_CLK);
            if (!vga_sync.hs) hs_low++;
            if (!vga_sync.vs) vs_low++;
         end
         expect_eq("hs low cycles per line", hs_low, H_SYNC);
      end
      expect_eq("vs low cycles per frame", vs_low, V_SYNC * H_TOTAL);
   endtask

   initial begin : watchdog
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge VGA_CTRL_CLK);
         cycles++;
      end
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      void'($urandom(99198));
      rst = 1'b1;
      clear_req = 1'b0;
      draw_req = 1'b0;
      eng_done = 1'b0;
      eng_wr = '0;
      repeat (4) @(posedge VGA_CTRL_CLK);
      rst <= 1'b0;
      check_reset_state();
      run_clear(1'b0);
      check_display();
      check_draw();
      run_clear(1'b1);
      check_sync_widths();
      @(negedge VGA_CTRL_CLK);
      errors += DUT.u_props.fail_count;
      $display("Checks %0d, errors %0d, property failures %0d",
               checks, errors, DUT.u_props.fail_count);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- test/sram_model.sv
`timescale 1ns/1ps

module sram_model #(
   parameter int A_BITS = 8
) (
   input  logic              VGA_CTRL_CLK,  // Only used to time writes
   input  logic [A_BITS-1:0] addr,
   inout  wire [15:0]        dq,
   input  logic              we_n
);

   logic [15:0] mem [0:(1<<A_BITS)-1];  // Backdoor array

   // Async read, bus released while written
   assign dq = we_n ? mem[addr] : 'z;

   // Write taken mid-cycle, address and data settled by then
   always @(negedge VGA_CTRL_CLK) begin
      if (!we_n) begin
         mem[addr] <= dq;
      end
   end

   // Power-up contents, unique per word
   initial begin
      for (int i = 0; i < (1 << A_BITS); i++) begin
         mem[i] = 16'(i) ^ 16'h5a5a;
      end
   end

endmodule

//--- verilog.f
verilog/fb_pkg.sv
verilog/vga_pkg.sv
verilog/frame_sequencer.sv
verilog/sram_arbiter.sv
verilog/vga_timing.sv
verilog/scanout.sv
verilog/fb_top.sv
test/sram_model.sv
test/fb_props.sv
test/fb_tb.sv

//--- verilog/fb_pkg.sv
package fb_pkg;

   // Stored colour field width
   localparam int COLOUR_W = 5;

   typedef logic [15:0]         fb_word_t;  // One SRAM word
   typedef logic [COLOUR_W-1:0] colour_t;   // One stored colour field
   typedef logic [19:0]         fb_addr_t;  // Largest supported framebuffer address

   // Word layout in SRAM, MSB first
   typedef struct packed {
      colour_t red;    // Bits 15..11
      colour_t green;  // Bits 10..6
      colour_t blue;   // Bits 5..1
      logic    spare;  // Bit 0, stored but not shown
   } fb_pixel_t;

   // Sequencer modes
   typedef enum logic [1:0] {
      mode_idle     = 2'd0,  // Scan-out owns the SRAM
      mode_clearing = 2'd1,  // Zero sweep in progress
      mode_drawing  = 2'd2   // Drawing engine owns the write port
   } fb_mode_e;

   // One write from the drawing engine
   typedef struct packed {
      fb_addr_t addr;  // Only the low X_BITS+Y_BITS bits reach the SRAM
      fb_word_t data;  // Word to store
      logic     we;    // Write this cycle
   } fb_write_t;

endpackage

//--- verilog/fb_top.sv
`timescale 1ns/1ps

module fb_top #(
   parameter int X_BITS   = 9,    // Framebuffer columns as a power of two
   parameter int Y_BITS   = 9,    // Framebuffer lines as a power of two
   parameter int H_ACTIVE = 640,
   parameter int H_FP     = 16,
   parameter int H_SYNC   = 96,
   parameter int H_BP     = 48,
   parameter int V_ACTIVE = 480,
   parameter int V_FP     = 10,
   parameter int V_SYNC   = 2,
   parameter int V_BP     = 33
) (
   input  logic                     VGA_CTRL_CLK,
   input  logic                     rst,
   input  logic                     clear_req,   // Start a clear sweep
   input  logic                     draw_req,    // Start a draw session
   input  fb_pkg::fb_write_t        eng_wr,      // Engine write, used only with grant
   input  logic                     eng_done,    // End of draw session
   output logic                     busy,
   output logic                     draw_grant,  // Engine may write
   output logic [X_BITS+Y_BITS-1:0] sram_addr,
   inout  wire fb_pkg::fb_word_t    sram_dq,
   output logic                     sram_we_n,
   output vga_pkg::vga_sync_t       vga_sync,
   output vga_pkg::rgb_t            vga_rgb
);
   import fb_pkg::*;
   import vga_pkg::*;

   fb_mode_e                  mode;
   logic [X_BITS+Y_BITS-1:0]  clear_addr;
   coord_t                    coord_x;
   coord_t                    coord_y;
   vga_sync_t                 sync_early;
   fb_word_t                  pix_word;
   logic                      pix_valid;

   assign draw_grant = (mode == mode_drawing);

   frame_sequencer #(
      .X_BITS (X_BITS),
      .Y_BITS (Y_BITS)
   ) u_seq (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .rst          (rst),
      .clear_req    (clear_req),
      .draw_req     (draw_req),
      .eng_done     (eng_done),
      .mode         (mode),
      .clear_addr   (clear_addr),
      .busy         (busy)
   );

   sram_arbiter #(
      .X_BITS (X_BITS),
      .Y_BITS (Y_BITS)
   ) u_arb (
      .mode       (mode),
      .clear_addr (clear_addr),
      .coord_x    (coord_x),
      .coord_y    (coord_y),
      .eng_wr     (eng_wr),
      .sram_addr  (sram_addr),
      .sram_dq    (sram_dq),
      .sram_we_n  (sram_we_n),
      .pix_word   (pix_word),
      .pix_valid  (pix_valid)
   );

   vga_timing #(
      .H_ACTIVE (H_ACTIVE), .H_FP (H_FP), .H_SYNC (H_SYNC), .H_BP (H_BP),
      .V_ACTIVE (V_ACTIVE), .V_FP (V_FP), .V_SYNC (V_SYNC), .V_BP (V_BP)
   ) u_timing (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .rst          (rst),
      .coord_x      (coord_x),
      .coord_y      (coord_y),
      .sync_early   (sync_early)
   );

   scanout u_scan (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .rst          (rst),
      .sync_early   (sync_early),
      .pix_word     (pix_word),
      .pix_valid    (pix_valid),
      .vga_sync     (vga_sync),
      .vga_rgb      (vga_rgb)
   );

endmodule

//--- verilog/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer #(
   parameter int X_BITS = 9,
   parameter int Y_BITS = 9
) (
   input  logic                     VGA_CTRL_CLK,
   input  logic                     rst,
   input  logic                     clear_req,   // Single-cycle strobe
   input  logic                     draw_req,    // Single-cycle strobe
   input  logic                     eng_done,    // Engine finished its session
   output fb_pkg::fb_mode_e         mode,
   output logic [X_BITS+Y_BITS-1:0] clear_addr,  // Current clear target
   output logic                     busy
);
   import fb_pkg::*;

   logic sweep_last;  // Final word of the clear sweep

   assign sweep_last = (clear_addr == '1);
   assign busy       = (mode != mode_idle);  // Any session running

   // Mode FSM
   always_ff @(posedge VGA_CTRL_CLK) begin
      if (rst) begin
         mode <= mode_idle;
      end else begin
         case (mode)
            mode_idle: begin
               if (clear_req) begin              // Clear wins a tie
                  mode <= mode_clearing;
               end else if (draw_req) begin
                  mode <= mode_drawing;
               end
            end
            mode_clearing: begin
               if (sweep_last) begin             // Idle right after the last write
                  mode <= mode_idle;
               end
            end
            mode_drawing: begin
               if (eng_done) begin               // Grant drops next cycle
                  mode <= mode_idle;
               end
            end
            default: begin
               mode <= mode_idle;                // Unused encoding
            end
         endcase
      end
   end

   // Clear sweep counter, ascending and wrapping to zero
   always_ff @(posedge VGA_CTRL_CLK) begin
      if (rst) begin
         clear_addr <= '0;
      end else if (mode == mode_clearing) begin
         clear_addr <= clear_addr + 1'b1;  // One word per cycle
      end else begin
         clear_addr <= '0;                 // Next sweep starts at word 0
      end
   end

endmodule

//--- verilog/scanout.sv
`timescale 1ns/1ps

module scanout (
   input  logic               VGA_CTRL_CLK,
   input  logic               rst,
   input  vga_pkg::vga_sync_t sync_early,  // Sync for the current coordinates
   input  fb_pkg::fb_word_t   pix_word,    // Word at the current coordinates
   input  logic               pix_valid,
   output vga_pkg::vga_sync_t vga_sync,
   output vga_pkg::rgb_t      vga_rgb
);
   import fb_pkg::*;
   import vga_pkg::*;

   localparam int PAD_W = DAC_W - COLOUR_W;  // Zero bits below each field

   fb_pixel_t pix;       // Word split into fields
   logic      show;      // Pixel visible this cycle
   rgb_t      rgb_next;

   assign pix  = fb_pixel_t'(pix_word);
   assign show = pix_valid && sync_early.blank_n;  // Black outside window and in blanking

   // Expand 5-bit fields to the DAC width
   always_comb begin
      rgb_next = '0;
      if (show) begin
         rgb_next.red   = {pix.red,   {PAD_W{1'b0}}};
         rgb_next.green = {pix.green, {PAD_W{1'b0}}};
         rgb_next.blue  = {pix.blue,  {PAD_W{1'b0}}};
      end
   end

   // Output stage, one cycle after the coordinates
   always_ff @(posedge VGA_CTRL_CLK) begin
      if (rst) begin
         vga_sync.hs      <= 1'b1;  // Syncs inactive
         vga_sync.vs      <= 1'b1;
         vga_sync.blank_n <= 1'b0;  // Blanked
         vga_rgb          <= '0;
      end else begin
         vga_sync <= sync_early;    // Same delay as colour
         vga_rgb  <= rgb_next;
      end
   end

endmodule

//--- verilog/sram_arbiter.sv
`timescale 1ns/1ps

module sram_arbiter #(
   parameter int X_BITS = 9,
   parameter int Y_BITS = 9
) (
   input  fb_pkg::fb_mode_e          mode,
   input  logic [X_BITS+Y_BITS-1:0]  clear_addr,
   input  vga_pkg::coord_t           coord_x,
   input  vga_pkg::coord_t           coord_y,
   input  fb_pkg::fb_write_t         eng_wr,      // Drawing engine port
   output logic [X_BITS+Y_BITS-1:0]  sram_addr,
   inout  wire fb_pkg::fb_word_t     sram_dq,
   output logic                      sram_we_n,
   output fb_pkg::fb_word_t          pix_word,    // Word read for scan-out
   output logic                      pix_valid    // Scan pixel inside the window
);
   import fb_pkg::*;
   import vga_pkg::*;

   localparam int A_BITS = X_BITS + Y_BITS;
   localparam int X_SPAN = 1 << X_BITS;  // Window width
   localparam int Y_SPAN = 1 << Y_BITS;  // Window height

   fb_word_t wr_data;  // Data driven onto the bus
   logic     wr_en;    // Write strobe, active high
   logic     x_in;
   logic     y_in;

   // Address, data and strobe per mode
   always_comb begin
      sram_addr = {coord_y[Y_BITS-1:0], coord_x[X_BITS-1:0]};  // Scan pixel by default
      wr_data   = '0;
      wr_en     = 1'b0;
      case (mode)
         mode_clearing: begin
            sram_addr = clear_addr;   // Zero sweep
            wr_en     = 1'b1;
         end
         mode_drawing: begin
            sram_addr = eng_wr.addr[A_BITS-1:0];  // Engine owns the port
            wr_data   = eng_wr.data;
            wr_en     = eng_wr.we;
         end
         default: begin
            wr_en = 1'b0;             // Idle only reads
         end
      endcase
   end

   assign sram_dq   = wr_en ? wr_data : 'z;  // Bus released while reading
   assign sram_we_n = ~wr_en;
   assign pix_word  = sram_dq;               // Async read data

   // Scan pixel must fit the addressable window
   assign x_in      = (int'(coord_x) < X_SPAN);
   assign y_in      = (int'(coord_y) < Y_SPAN);
   assign pix_valid = (mode == mode_idle) && x_in && y_in;

endmodule

//--- verilog/vga_pkg.sv
package vga_pkg;

   // Output DAC width per channel
   localparam int DAC_W = 10;

   typedef logic [9:0]       coord_t;  // Screen coordinate
   typedef logic [DAC_W-1:0] dac_t;    // One DAC channel

   // Colour sent to the DAC
   typedef struct packed {
      dac_t red;
      dac_t green;
      dac_t blue;
   } rgb_t;

   // Sync and blank, all active low
   typedef struct packed {
      logic hs;       // Horizontal sync
      logic vs;       // Vertical sync
      logic blank_n;  // Low outside the active area
   } vga_sync_t;

endpackage

//--- verilog/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
   parameter int H_ACTIVE = 640,
   parameter int H_FP     = 16,
   parameter int H_SYNC   = 96,
   parameter int H_BP     = 48,
   parameter int V_ACTIVE = 480,
   parameter int V_FP     = 10,
   parameter int V_SYNC   = 2,
   parameter int V_BP     = 33
) (
   input  logic               VGA_CTRL_CLK,
   input  logic               rst,
   output vga_pkg::coord_t    coord_x,     // Current column
   output vga_pkg::coord_t    coord_y,     // Current line
   output vga_pkg::vga_sync_t sync_early   // Unregistered sync and blank
);
   import vga_pkg::*;

   // Line layout is active, front porch, sync, back porch
   localparam int H_TOTAL      = H_ACTIVE + H_FP + H_SYNC + H_BP;
   localparam int H_SYNC_START = H_ACTIVE + H_FP;
   localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
   // Frame layout in lines, same order
   localparam int V_TOTAL      = V_ACTIVE + V_FP + V_SYNC + V_BP;
   localparam int V_SYNC_START = V_ACTIVE + V_FP;
   localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

   coord_t h_cnt;      // Pixel within line
   coord_t v_cnt;      // Line within frame
   logic   line_end;
   logic   frame_end;
   logic   h_pulse;    // Inside horizontal sync
   logic   v_pulse;    // Inside vertical sync
   logic   h_active;
   logic   v_active;

   assign line_end  = (h_cnt == coord_t'(H_TOTAL - 1));
   assign frame_end = (v_cnt == coord_t'(V_TOTAL - 1));

   // Pixel and line counters
   always_ff @(posedge VGA_CTRL_CLK) begin
      if (rst) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (line_end) begin
         h_cnt <= '0;
         if (frame_end) begin
            v_cnt <= '0;            // New frame
         end else begin
            v_cnt <= v_cnt + 1'b1;  // Next line
         end
      end else begin
         h_cnt <= h_cnt + 1'b1;
      end
   end

   // Sync windows
   assign h_pulse  = (h_cnt >= coord_t'(H_SYNC_START)) && (h_cnt < coord_t'(H_SYNC_END));
   assign v_pulse  = (v_cnt >= coord_t'(V_SYNC_START)) && (v_cnt < coord_t'(V_SYNC_END));

   // Active video first in line and frame
   assign h_active = (h_cnt < coord_t'(H_ACTIVE));
   assign v_active = (v_cnt < coord_t'(V_ACTIVE));

   assign sync_early.hs      = ~h_pulse;
   assign sync_early.vs      = ~v_pulse;
   assign sync_early.blank_n = h_active && v_active;

   assign coord_x = h_cnt;  // Pixel coordinates
   assign coord_y = v_cnt;

endmodule
